// ==== common/chip_pkg.sv ====
package chip_pkg;

    // Output select on uio_in[1:0], one code per measurement block
    localparam int SEL_W = 2;
    localparam logic [SEL_W-1:0] SEL_SENSOR = 2'd0;  // Pulse launcher status
    localparam logic [SEL_W-1:0] SEL_TDC    = 2'd1;  // TDC result byte
    localparam logic [SEL_W-1:0] SEL_RO1    = 2'd2;  // Short ring count
    localparam logic [SEL_W-1:0] SEL_RO2    = 2'd3;  // Long ring count

    // Johnson ring lengths, last stage rises every 2N cycles
    localparam int RO1_STAGES = 5;
    localparam int RO2_STAGES = 7;

    // Frequency counter windows in clk cycles
    localparam int GATE_SHORT = 64;
    localparam int GATE_LONG  = 128;

    // Dedicated input pins
    localparam int UI_TDC_MODE  = 0;  // 0 raw taps, 1 encoded count
    localparam int UI_RO1_EN    = 1;  // Ring 1 enable
    localparam int UI_RO1_GATE  = 2;  // Ring 1 long window
    localparam int UI_RO2_EN    = 3;  // Ring 2 enable
    localparam int UI_RO2_GATE  = 4;  // Ring 2 long window
    localparam int UI_DELAY_LSB = 5;  // Delay code field
    localparam int UI_DELAY_MSB = 7;

    // Bidirectional pins, used as inputs only
    localparam int UIO_SEL_LSB = 0;  // Output select field
    localparam int UIO_SEL_MSB = 1;
    localparam int UIO_REQ     = 2;  // Measurement request, edge triggered

endpackage

// ==== common/tdc_pkg.sv ====
package tdc_pkg;

    // Delay line stand-in, one register per tap
    localparam int DELAY_TAPS   = 8;
    localparam int DELAY_CODE_W = 3;  // Capture delay D, capture after D+1 cycles

    // Tap count needs to hold 0 to DELAY_TAPS
    localparam int TAP_CNT_W = 4;

    // One result byte, read either as raw taps or as an encoded count
    typedef union packed {
        logic [DELAY_TAPS-1:0] raw;       // Thermometer, tap 0 in bit 0
        struct packed {
            logic                 valid;  // Count agrees with launched delay
            logic [2:0]           zero;   // Always zero
            logic [TAP_CNT_W-1:0] count;  // Leading ones from tap 0
        } enc;
    } tdc_result_t;

endpackage

// ==== common/strobe_if.sv ====
interface strobe_if;
    import tdc_pkg::*;

    logic                    launch;      // Start edge, held for the whole measurement
    logic                    capture;     // Single cycle freeze strobe
    logic [DELAY_CODE_W-1:0] delay_code;  // Code latched at the request edge
    logic                    busy;        // Measurement in flight

    // Launcher owns every signal, the TDC only watches
    modport launcher (
        output launch,
        output capture,
        output delay_code,
        output busy
    );

    modport tdc (
        input launch,
        input capture,
        input delay_code,
        input busy
    );

endinterface

// ==== tdc/pulse_launcher.sv ====
module pulse_launcher (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             request_i,
    input  logic [tdc_pkg::DELAY_CODE_W-1:0] delay_code_i,
    strobe_if.launcher                       strobe,
    output logic [7:0]                       status_o
);
    import tdc_pkg::*;

    logic                    request_q;  // Request pin one cycle back
    logic                    start;      // Rising request while idle
    logic [DELAY_CODE_W-1:0] wait_cnt;   // Cycles since launch rose

    // Requests during a measurement are dropped
    assign start = request_i && !request_q && !strobe.busy;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            request_q         <= 1'b0;
            wait_cnt          <= '0;
            strobe.launch     <= 1'b0;
            strobe.capture    <= 1'b0;
            strobe.busy       <= 1'b0;
            strobe.delay_code <= '0;
        end else begin
            request_q <= request_i;
            if (start) begin
                strobe.launch     <= 1'b1;  // Launch and busy rise together
                strobe.busy       <= 1'b1;
                strobe.delay_code <= delay_code_i;
                wait_cnt          <= '0;
            end else if (strobe.capture) begin
                // Capture edge ends the measurement
                strobe.capture <= 1'b0;
                strobe.launch  <= 1'b0;
                strobe.busy    <= 1'b0;
            end else if (strobe.busy) begin
                wait_cnt <= wait_cnt + 1'b1;
                // Fires D+1 cycles after launch rose
                if (wait_cnt == strobe.delay_code) begin
                    strobe.capture <= 1'b1;
                end
            end
        end
    end

    // Sensor byte, bits 4:3 unused
    assign status_o = {strobe.delay_code, 2'b00, strobe.busy, strobe.capture, strobe.launch};

endmodule

// ==== tdc/tdc_capture.sv ====
module tdc_capture (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       mode_i,    // 0 raw taps, 1 encoded count
    strobe_if.tdc      strobe,
    output logic [7:0] result_o
);
    import tdc_pkg::*;

    logic [DELAY_TAPS-1:0] taps_q;       // Delay line, tap 0 nearest launch
    logic [TAP_CNT_W-1:0]  tap_count;    // Leading ones of the line
    logic [TAP_CNT_W-1:0]  tap_expect;   // D+1 from the launcher
    logic                  tap_match;
    tdc_result_t           next_result;
    tdc_result_t           result_q;     // Holds until next capture

    // Count ones from tap 0 up to the first zero
    always_comb begin
        logic run;
        run       = 1'b1;
        tap_count = '0;
        for (int i = 0; i < DELAY_TAPS; i++) begin
            if (run && taps_q[i]) begin
                tap_count = tap_count + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
    end

    // Launched delay says how many taps should have filled
    assign tap_expect = TAP_CNT_W'(strobe.delay_code) + TAP_CNT_W'(1);
    assign tap_match  = (tap_count == tap_expect);

    always_comb begin
        next_result = '0;  // Keeps the three zero bits clear
        if (mode_i) begin
            next_result.enc.valid = tap_match;
            next_result.enc.count = tap_count;
        end else begin
            next_result.raw = taps_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            taps_q   <= '0;
            result_q <= '0;
        end else if (strobe.capture) begin
            result_q <= next_result;  // Freeze taps as they stand
            taps_q   <= '0;           // Line empties for the next run
        end else if (strobe.busy) begin
            taps_q <= {taps_q[DELAY_TAPS-2:0], strobe.launch};  // One tap per cycle
        end else begin
            taps_q <= '0;
        end
    end

    assign result_o = result_q;

endmodule

// ==== verilog/ring_osc_counter.sv ====
module ring_osc_counter #(
    parameter int RING_STAGES = chip_pkg::RO1_STAGES
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       enable_i,     // Low holds ring and counts cleared
    input  logic       gate_long_i,  // Selects the long window
    output logic [7:0] count_o       // Edges in the last full window
);
    import chip_pkg::*;

    logic [RING_STAGES-1:0] ring_q;      // Johnson ring, output is the last stage
    logic [7:0]             win_cnt_q;   // Position inside the window
    logic [7:0]             edge_cnt_q;  // Rising edges so far this window
    logic [7:0]             gate_last;   // Index of the final window cycle
    logic                   window_end;
    logic                   ring_rise;   // Last stage goes high on this shift

    assign gate_last = gate_long_i ? 8'(GATE_LONG - 1) : 8'(GATE_SHORT - 1);

    // Covers a window shortened by a gate change mid-window
    assign window_end = (win_cnt_q >= gate_last);

    // Stage before the output already high, output still low
    assign ring_rise = ring_q[RING_STAGES-2] & ~ring_q[RING_STAGES-1];

    always_ff @(posedge clk) begin
        if (reset_i || !enable_i) begin
            ring_q     <= '0;
            win_cnt_q  <= '0;
            edge_cnt_q <= '0;
            count_o    <= '0;
        end else if (window_end) begin
            count_o    <= edge_cnt_q;  // Latch and start a fresh window
            edge_cnt_q <= '0;
            win_cnt_q  <= '0;
            ring_q     <= '0;          // Ring restarts from all zeros
        end else begin
            ring_q    <= {ring_q[RING_STAGES-2:0], ~ring_q[RING_STAGES-1]};
            win_cnt_q <= win_cnt_q + 1'b1;
            if (ring_rise) begin
                edge_cnt_q <= edge_cnt_q + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/tdc_test_chip.sv ====
module tdc_test_chip (
    input  logic       clk,
    input  logic       reset_i,
    input  logic [7:0] ui_in_i,    // Block controls and delay code
    input  logic [7:0] uio_in_i,   // Output select and request
    output logic [7:0] uo_out_o,   // Selected block byte
    output logic [7:0] uio_out_o,
    output logic [7:0] uio_oe_o    // Bidir pins stay inputs
);
    import chip_pkg::*;
    import tdc_pkg::*;

    logic [SEL_W-1:0]        sel;
    logic                    request;
    logic [DELAY_CODE_W-1:0] delay_code;
    logic [7:0]              sensor_byte;
    logic [7:0]              tdc_byte;
    logic [7:0]              ro1_byte;
    logic [7:0]              ro2_byte;

    // Pin decode
    assign sel        = uio_in_i[UIO_SEL_MSB:UIO_SEL_LSB];
    assign request    = uio_in_i[UIO_REQ];
    assign delay_code = ui_in_i[UI_DELAY_MSB:UI_DELAY_LSB];

    strobe_if strobe ();

    pulse_launcher u_launcher (
        .clk          (clk),
        .reset_i      (reset_i),
        .request_i    (request),
        .delay_code_i (delay_code),
        .strobe       (strobe.launcher),
        .status_o     (sensor_byte)
    );

    // Same clk as the launcher, the delay line is a register chain
    tdc_capture u_tdc (
        .clk      (clk),
        .reset_i  (reset_i),
        .mode_i   (ui_in_i[UI_TDC_MODE]),
        .strobe   (strobe.tdc),
        .result_o (tdc_byte)
    );

    ring_osc_counter #(.RING_STAGES(RO1_STAGES)) u_ro1 (
        .clk         (clk),
        .reset_i     (reset_i),
        .enable_i    (ui_in_i[UI_RO1_EN]),
        .gate_long_i (ui_in_i[UI_RO1_GATE]),
        .count_o     (ro1_byte)
    );

    ring_osc_counter #(.RING_STAGES(RO2_STAGES)) u_ro2 (
        .clk         (clk),
        .reset_i     (reset_i),
        .enable_i    (ui_in_i[UI_RO2_EN]),
        .gate_long_i (ui_in_i[UI_RO2_GATE]),
        .count_o     (ro2_byte)
    );

    // Shared output bus
    always_comb begin
        case (sel)
            SEL_SENSOR: uo_out_o = sensor_byte;
            SEL_TDC:    uo_out_o = tdc_byte;
            SEL_RO1:    uo_out_o = ro1_byte;
            default:    uo_out_o = ro2_byte;  // SEL_RO2
        endcase
    end

    assign uio_out_o = 8'h00;
    assign uio_oe_o  = 8'h00;

endmodule

// ==== test/tdc_test_chip_props.sv ====
module tdc_test_chip_props (
    input logic clk,
    input logic reset_i,
    input logic launch,
    input logic capture,
    input logic busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // Capture only freezes a line that launch is feeding
    property capture_needs_launch;
        @(posedge clk) disable iff (reset_i) capture |-> launch;
    endproperty

    property capture_single_cycle;
        @(posedge clk) disable iff (reset_i) capture |=> !capture;
    endproperty

    // Measurement closes right behind the capture edge
    property busy_drops_after_capture;
        @(posedge clk) disable iff (reset_i) capture |=> !busy;
    endproperty

    a_capture_needs_launch: assert property (capture_needs_launch)
        else $error("Capture seen without launch");
    a_capture_single_cycle: assert property (capture_single_cycle)
        else $error("Capture held longer than one cycle");
    a_busy_drops: assert property (busy_drops_after_capture)
        else $error("Busy still high the cycle after capture");

endmodule

// ==== test/tdc_test_chip_tb.sv ====
module tdc_test_chip_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import chip_pkg::*;
    import tdc_pkg::*;

    typedef enum {OP_IDLE, OP_MEASURE, OP_REISSUE, OP_RING, OP_RING_OFF} op_t;

    typedef struct {
        string                   name;
        op_t                     op;
        logic [SEL_W-1:0]        sel;       // Output select while checking
        logic                    mode;      // TDC view, 1 encoded
        logic [DELAY_CODE_W-1:0] delay;
        logic [3:0]              ring_ctl;  // ui_in[4:1], ring 2 gate down to ring 1 enable
        logic [7:0]              expected;
    } row_t;

    logic        clk;
    logic        reset;
    logic [7:0]  ui_in;
    logic [7:0]  uio_in;
    logic [7:0]  uo_out;
    logic [7:0]  uio_out;
    logic [7:0]  uio_oe;
    row_t        rows[$];
    logic [31:0] rng_state;

    tdc_test_chip DUT (
        .clk       (clk),
        .reset_i   (reset),
        .ui_in_i   (ui_in),
        .uio_in_i  (uio_in),
        .uo_out_o  (uo_out),
        .uio_out_o (uio_out),
        .uio_oe_o  (uio_oe)
    );

    // Strobe rules checked from both ends of the interface
    bind pulse_launcher tdc_test_chip_props launcher_props (.clk(clk), .reset_i(reset_i),
        .launch(status_o[0]), .capture(status_o[1]), .busy(status_o[2]));
    bind tdc_capture tdc_test_chip_props tdc_props (.clk(clk), .reset_i(reset_i),
        .launch(strobe.launch), .capture(strobe.capture), .busy(strobe.busy));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Noise for uio_in[7:3], which the chip ignores
    function automatic logic [4:0] next_filler();
        rng_state = xorshift32(rng_state);
        return rng_state[4:0];
    endfunction

    // Last stage first rises N cycles into the window, then every 2N
    function automatic int ring_edges(input int n, input int g);
        int cnt;
        cnt = 0;
        for (int t = n; t < g; t += 2 * n) begin
            cnt++;
        end
        return cnt;
    endfunction

    function automatic int gate_window(input logic [3:0] ctl);
        if ((ctl[0] && ctl[1]) || (ctl[2] && ctl[3])) return GATE_LONG;  // Any enabled long gate
        return GATE_SHORT;
    endfunction

    task automatic add_row(input string name, input op_t op, input logic [SEL_W-1:0] sel,
                           input logic mode, input logic [DELAY_CODE_W-1:0] delay,
                           input logic [3:0] ctl, input logic [7:0] expected);
        rows.push_back('{name, op, sel, mode, delay, ctl, expected});
    endtask

    task automatic build_table();
        tdc_result_t r;
        add_row("reset sensor", OP_IDLE, SEL_SENSOR, 1'b0, 3'd0, 4'b0000, 8'h00);
        add_row("reset tdc", OP_IDLE, SEL_TDC, 1'b0, 3'd0, 4'b0000, 8'h00);
        add_row("reset ro1", OP_IDLE, SEL_RO1, 1'b0, 3'd0, 4'b0000, 8'h00);
        add_row("reset ro2", OP_IDLE, SEL_RO2, 1'b0, 3'd0, 4'b0000, 8'h00);
        for (int d = 0; d < 2 ** DELAY_CODE_W; d++) begin
            r = '0;
            r.enc.valid = 1'b1;
            r.enc.count = TAP_CNT_W'(d + 1);  // D+1 taps filled at capture
            add_row($sformatf("encoded d%0d", d), OP_MEASURE, SEL_TDC, 1'b1,
                    DELAY_CODE_W'(d), 4'b0000, r);
        end
        for (int d = 0; d < 2 ** DELAY_CODE_W; d++) begin
            r = '0;
            for (int k = 0; k <= d; k++) begin
                r.raw[k] = 1'b1;  // Thermometer from tap 0
            end
            add_row($sformatf("raw d%0d", d), OP_MEASURE, SEL_TDC, 1'b0, DELAY_CODE_W'(d),
                    4'b0000, r);
        end
        add_row("sensor d5", OP_MEASURE, SEL_SENSOR, 1'b1, 3'd5, 4'b0000, {3'd5, 5'b00000});
        r = '0;
        r.enc.valid = 1'b1;
        r.enc.count = 4'd8;
        add_row("reissue tdc", OP_REISSUE, SEL_TDC, 1'b1, 3'd7, 4'b0000, r);
        add_row("reissue sensor", OP_IDLE, SEL_SENSOR, 1'b1, 3'd7, 4'b0000, {3'd7, 5'b00000});
        add_row("ro1 short", OP_RING, SEL_RO1, 1'b1, 3'd0, 4'b0001,
                8'(ring_edges(RO1_STAGES, GATE_SHORT)));
        add_row("ro1 long", OP_RING, SEL_RO1, 1'b1, 3'd0, 4'b0011,
                8'(ring_edges(RO1_STAGES, GATE_LONG)));
        add_row("ro2 short", OP_RING, SEL_RO2, 1'b1, 3'd0, 4'b0100,
                8'(ring_edges(RO2_STAGES, GATE_SHORT)));
        add_row("ro2 long", OP_RING, SEL_RO2, 1'b1, 3'd0, 4'b1100,
                8'(ring_edges(RO2_STAGES, GATE_LONG)));
        add_row("both ro1", OP_RING, SEL_RO1, 1'b1, 3'd0, 4'b1101,
                8'(ring_edges(RO1_STAGES, GATE_SHORT)));
        add_row("both ro2", OP_IDLE, SEL_RO2, 1'b1, 3'd0, 4'b1101,
                8'(ring_edges(RO2_STAGES, GATE_LONG)));
        add_row("ro1 off", OP_RING_OFF, SEL_RO1, 1'b1, 3'd0, 4'b1100, 8'h00);
        add_row("ro2 kept", OP_IDLE, SEL_RO2, 1'b1, 3'd0, 4'b1100,
                8'(ring_edges(RO2_STAGES, GATE_LONG)));
    endtask

    task automatic drive_pins(input logic [SEL_W-1:0] sel, input logic req, input logic mode,
                              input logic [DELAY_CODE_W-1:0] delay, input logic [3:0] ctl);
        @(posedge clk);
        ui_in  <= {delay, ctl, mode};
        uio_in <= {next_filler(), req, sel};
    endtask

    // Sensor byte bit 2, polled mid-cycle
    task automatic wait_busy(input logic level);
        do begin
            @(negedge clk);
        end while (uo_out[2] !== level);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %02h, actual %02h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic run_row(input row_t row);
        case (row.op)
            OP_IDLE: begin  // Only the select moves
                drive_pins(row.sel, 1'b0, ui_in[UI_TDC_MODE], ui_in[UI_DELAY_MSB:UI_DELAY_LSB],
                           ui_in[UI_RO2_GATE:UI_RO1_EN]);
                @(negedge clk);
                check_value(row.name, row.expected, uo_out);
                check_value({row.name, " uio_out"}, 8'h00, uio_out);
                check_value({row.name, " uio_oe"}, 8'h00, uio_oe);
            end
            OP_MEASURE, OP_REISSUE: begin
                drive_pins(SEL_SENSOR, 1'b0, row.mode, row.delay, row.ring_ctl);
                drive_pins(SEL_SENSOR, 1'b1, row.mode, row.delay, row.ring_ctl);  // Request edge
                wait_busy(1'b1);
                if (row.op == OP_REISSUE) begin
                    // Fresh edge with another code while the launcher is busy
                    drive_pins(SEL_SENSOR, 1'b0, row.mode, ~row.delay, row.ring_ctl);
                    drive_pins(SEL_SENSOR, 1'b1, row.mode, ~row.delay, row.ring_ctl);
                end
                drive_pins(SEL_SENSOR, 1'b0, row.mode, row.delay, row.ring_ctl);
                wait_busy(1'b0);  // Result register loads as busy falls
                drive_pins(row.sel, 1'b0, row.mode, row.delay, row.ring_ctl);
                @(negedge clk);
                check_value(row.name, row.expected, uo_out);
            end
            OP_RING: begin
                drive_pins(row.sel, 1'b0, row.mode, row.delay, row.ring_ctl & 4'b1010);
                drive_pins(row.sel, 1'b0, row.mode, row.delay, row.ring_ctl);
                repeat (2 * gate_window(row.ring_ctl) + 4) @(posedge clk);  // Two full windows
                @(negedge clk);
                check_value(row.name, row.expected, uo_out);
            end
            default: begin
                drive_pins(row.sel, 1'b0, row.mode, row.delay, row.ring_ctl);
                @(posedge clk);  // Ring sees enable low here
                @(negedge clk);
                check_value(row.name, row.expected, uo_out);
            end
        endcase
    endtask

    initial begin
        reset     = 1'b1;
        ui_in     = '0;
        uio_in    = '0;
        rng_state = 32'd94;
        build_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        int limit;
        @(posedge clk);
        limit = rows.size() * (2 * GATE_LONG + 20);  // Budget per row covers two long windows
        repeat (limit) @(posedge clk);
        $display("Timeout: the table did not finish within %0d cycles", limit);
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== tdc_test_chip.f ====
common/chip_pkg.sv
common/tdc_pkg.sv
common/strobe_if.sv
tdc/pulse_launcher.sv
tdc/tdc_capture.sv
verilog/ring_osc_counter.sv
verilog/tdc_test_chip.sv
test/tdc_test_chip_props.sv
test/tdc_test_chip_tb.sv

// ==== Makefile ====
TOP = tdc_test_chip_tb

all:
	verilator --binary --timing --assert --top-module $(TOP) -f tdc_test_chip.f -o sim
	@out=$$(./obj_dir/sim 2>&1); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tdc_test_chip.f

clean:
	rm -rf obj_dir

.PHONY: all lint clean
